// File: dcache.f
rtl/dcache_pkg.sv
rtl/cache_array.sv
rtl/access_controller.sv
rtl/dcache_top.sv
verif/tb_clock.sv
verif/tb_memory.sv
verif/tb_checker.sv
verif/tb_top.sv

// File: rtl/access_controller.sv
`default_nettype none

module access_controller
    import dcache_pkg::*;
#(
    // Words per block as a power of two, at least 1
    parameter int OFFSET = 2,
    // Lines in the cache as a power of two
    parameter int INDEX  = 4
) (
    input  wire logic                          clk_i,
    input  wire logic                          rst_n_i,

    // Core side
    input  wire logic                          req_i,
    input  wire core_req_t                     req_data_i,
    output logic                               ready_o,
    output data_word_t                         rdata_o,
    output logic                               valid_o,

    // Memory channels
    output load_req_t                          load_req_o,
    input  wire load_rsp_t                     load_rsp_i,
    output store_req_t                         store_req_o,
    input  wire logic                          store_done_i,

    // Array results, valid one cycle after a read enable
    input  wire logic                          arr_hit_i,
    input  wire logic                          arr_dirty_i,
    input  wire logic [30-INDEX-OFFSET-1:0]    arr_tag_i,
    input  wire data_word_t                    arr_data_i,

    // Array commands
    output data_word_t                         arr_addr_o,
    output data_enable_t                       arr_read_o,
    output data_enable_t                       arr_write_o,
    output data_word_t                         arr_wdata_o,
    output status_t                            arr_status_o
);

    localparam int TAG_W = 30 - INDEX - OFFSET;

    typedef struct packed {
        logic [TAG_W-1:0]  tag;
        logic [INDEX-1:0]  index;
        logic [OFFSET-1:0] offset;
        logic [1:0]        align;
    } addr_fields_t;

    typedef enum logic [1:0] {IDLE, OUTCOME, WRITE_BACK, ALLOCATE} state_t;

    state_t            state_q, state_d;
    logic [OFFSET:0]   count_q, count_d;
    data_word_t        saved_q, saved_d;
    core_req_t         req_q;
    addr_fields_t      req_addr;
    logic              load_strobe;
    logic              store_strobe;
    logic              store_word;
    logic [OFFSET-1:0] wb_word;

    assign req_addr = req_q.addr;

    // Write-back reads run one word ahead, so the word on the store channel
    // is the one before the counter
    assign wb_word = count_q[OFFSET-1:0] - 1'b1;

    // During a store miss the fill word at the requested offset is replaced
    assign store_word = req_q.write && (count_q[OFFSET-1:0] == req_addr.offset);

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            state_q <= IDLE;
            count_q <= '0;
        end else begin
            state_q <= state_d;
            count_q <= count_d;
        end
    end

    // The request is only taken while idle and then held for the whole access
    always_ff @(posedge clk_i) begin
        saved_q <= saved_d;
        if (ready_o && req_i) begin
            req_q <= req_data_i;
        end
    end

    always_comb begin
        state_d      = state_q;
        count_d      = count_q;
        saved_d      = saved_q;
        load_strobe  = 1'b0;
        store_strobe = 1'b0;
        arr_read_o   = '0;
        arr_write_o  = '0;
        arr_addr_o   = {req_addr.tag, req_addr.index, count_q[OFFSET-1:0], 2'b00};
        arr_wdata_o  = '0;
        arr_status_o = '0;
        rdata_o      = '0;
        valid_o      = 1'b0;

        case (state_q)
            // Probe the whole entry as soon as a request shows up
            IDLE: begin
                arr_addr_o = req_data_i.addr;
                count_d    = '0;
                if (req_i) begin
                    arr_read_o = '1;
                    state_d    = OUTCOME;
                end
            end

            // The probe result is on the array outputs now
            OUTCOME: begin
                if (arr_hit_i) begin
                    valid_o = 1'b1;
                    state_d = IDLE;
                    if (req_q.write) begin
                        // Store hit updates the word and marks the line dirty
                        arr_addr_o         = req_q.addr;
                        arr_write_o.status = 1'b1;
                        arr_write_o.data   = 1'b1;
                        arr_wdata_o        = req_q.wdata;
                        arr_status_o       = '{valid: 1'b1, dirty: 1'b1};
                    end else begin
                        rdata_o = arr_data_i;
                    end
                end else if (arr_dirty_i) begin
                    // Old block must go first, starting with its base word
                    arr_read_o.data = 1'b1;
                    arr_addr_o = {arr_tag_i, req_addr.index, {OFFSET{1'b0}}, 2'b00};
                    count_d    = {{OFFSET{1'b0}}, 1'b1};
                    state_d    = WRITE_BACK;
                end else begin
                    load_strobe = 1'b1;
                    state_d     = ALLOCATE;
                end
            end

            // Stored tag stays on the array outputs since only data is read here
            WRITE_BACK: begin
                arr_addr_o = {arr_tag_i, req_addr.index, count_q[OFFSET-1:0], 2'b00};
                if (store_done_i) begin
                    // Memory holds the old block and the fill request follows next cycle
                    count_d = {1'b1, {OFFSET{1'b0}}};
                    state_d = ALLOCATE;
                end else if (!count_q[OFFSET] && (count_q[OFFSET-1:0] != '0)) begin
                    // Read the next word while the previous one goes out
                    arr_read_o.data = 1'b1;
                    store_strobe    = 1'b1;
                    count_d         = count_q + 1'b1;
                end else if (count_q[OFFSET] && (count_q[OFFSET-1:0] == '0)) begin
                    // Last word of the block, nothing left to read
                    store_strobe = 1'b1;
                    count_d      = count_q + 1'b1;
                end
            end

            // Words arrive in ascending order with arbitrary gaps
            ALLOCATE: begin
                if (count_q[OFFSET]) begin
                    // After a write-back the fill has not been requested yet
                    load_strobe = 1'b1;
                    count_d     = '0;
                end else if (load_rsp_i.valid) begin
                    count_d          = count_q + 1'b1;
                    arr_write_o.data = 1'b1;
                    arr_wdata_o      = store_word ? req_q.wdata : load_rsp_i.data;

                    // First word brings the new tag, line is valid and clean
                    if (count_q[OFFSET-1:0] == '0) begin
                        arr_write_o  = '1;
                        arr_status_o = '{valid: 1'b1, dirty: 1'b0};
                    end

                    // The last word closes the fill, a store leaves it dirty
                    if (count_q[OFFSET-1:0] == '1) begin
                        arr_write_o.status = 1'b1;
                        arr_status_o       = '{valid: 1'b1, dirty: req_q.write};
                        valid_o            = 1'b1;
                        state_d            = IDLE;
                        // The last word itself may be the one that was asked for
                        rdata_o = (req_addr.offset == '1) ? load_rsp_i.data : saved_q;
                    end

                    if (count_q[OFFSET-1:0] == req_addr.offset) begin
                        saved_d = load_rsp_i.data;
                    end
                end
            end

            default: begin
                state_d = IDLE;
            end
        endcase
    end

    assign ready_o = (state_q == IDLE);

    assign load_req_o = '{
        req:  load_strobe,
        addr: {req_addr.tag, req_addr.index, {OFFSET{1'b0}}, 2'b00}
    };

    assign store_req_o = '{
        req:  store_strobe,
        addr: {arr_tag_i, req_addr.index, wb_word, 2'b00},
        data: arr_data_i
    };

    // Only one memory channel is active in any cycle
    a_one_channel: assert property (
        @(posedge clk_i) disable iff (!rst_n_i)
        !(load_req_o.req && store_req_o.req)
    );

    // Completion is only signalled for an accepted request
    a_no_valid_idle: assert property (
        @(posedge clk_i) disable iff (!rst_n_i)
        (state_q == IDLE) |-> !valid_o
    );

endmodule : access_controller

`default_nettype wire

// File: rtl/cache_array.sv
`default_nettype none

module cache_array
    import dcache_pkg::*;
#(
    // Words per block as a power of two
    parameter int OFFSET = 2,
    // Lines in the cache as a power of two
    parameter int INDEX  = 4
) (
    input  wire logic                          clk_i,
    input  wire logic                          rst_n_i,

    // Shared address for reads and writes
    input  wire data_word_t                    addr_i,
    input  wire data_enable_t                  read_i,
    input  wire data_enable_t                  write_i,
    input  wire data_word_t                    wdata_i,
    input  wire status_t                       wstatus_i,

    // Registered read results
    output logic                               hit_o,
    output logic                               dirty_o,
    output logic [30-INDEX-OFFSET-1:0]         tag_o,
    output data_word_t                         rdata_o
);

    localparam int TAG_W = 30 - INDEX - OFFSET;
    localparam int LINES = 2 ** INDEX;
    localparam int WORDS = 2 ** (INDEX + OFFSET);

    // Storage, one tag and status pair per line and one word per slot
    logic [TAG_W-1:0] tag_mem    [LINES];
    status_t          status_mem [LINES];
    data_word_t       data_mem   [WORDS];

    // Address fields
    logic [TAG_W-1:0]        addr_tag;
    logic [INDEX-1:0]        addr_index;
    logic [INDEX+OFFSET-1:0] addr_word;

    // Read side registers
    logic [TAG_W-1:0] tag_q;
    logic [TAG_W-1:0] req_tag_q;
    status_t          status_q;
    data_word_t       data_q;

    // Bits 1:0 select a byte and are not used by a word cache
    assign addr_tag   = addr_i[WORD_W-1 -: TAG_W];
    assign addr_index = addr_i[2+OFFSET +: INDEX];
    assign addr_word  = addr_i[2 +: INDEX+OFFSET];

    // Status bits start out cleared so every line is invalid after reset
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            for (int i = 0; i < LINES; i++) begin
                status_mem[i] <= '0;
            end
        end else if (write_i.status) begin
            status_mem[addr_index] <= wstatus_i;
        end
    end

    // Tags and data words carry no reset
    always_ff @(posedge clk_i) begin
        if (write_i.tag) begin
            tag_mem[addr_index] <= addr_tag;
        end
        if (write_i.data) begin
            data_mem[addr_word] <= wdata_i;
        end
    end

    // The status output register is reset so that hit and dirty start low
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            status_q <= '0;
        end else if (read_i.status) begin
            status_q <= status_mem[addr_index];
        end
    end

    // Tag and data reads land one cycle after the enable
    always_ff @(posedge clk_i) begin
        if (read_i.tag) begin
            tag_q     <= tag_mem[addr_index];
            // Keep the requested tag so the compare lines up with the stored one
            req_tag_q <= addr_tag;
        end
        if (read_i.data) begin
            data_q <= data_mem[addr_word];
        end
    end

    // A hit needs a valid line whose tag matches the tag that was asked for
    assign hit_o   = status_q.valid && (tag_q == req_tag_q);
    assign dirty_o = status_q.dirty;
    assign tag_o   = tag_q;
    assign rdata_o = data_q;

    // The controller never updates an entry while it probes its metadata
    a_no_write_on_probe: assert property (
        @(posedge clk_i) disable iff (!rst_n_i)
        (read_i.tag || read_i.status) |-> (write_i == '0)
    );

endmodule : cache_array

`default_nettype wire

// File: rtl/dcache_pkg.sv
`default_nettype none

package dcache_pkg;

    // Width of a data word and of a byte address
    localparam int WORD_W = 32;

    // One 32-bit word as stored in the cache and in memory
    typedef logic [WORD_W-1:0] data_word_t;

    // Per-line status bits
    // A line is dirty only while it is also valid
    typedef struct packed {
        logic valid;
        logic dirty;
    } status_t;

    // Field enables toward the storage array
    // Setting all three bits addresses the whole entry
    typedef struct packed {
        logic tag;
        logic status;
        logic data;
    } data_enable_t;

    // Request presented by the core together with its strobe
    // The address is a byte address of an aligned word, so bits 1:0 are ignored
    typedef struct packed {
        logic       write;
        data_word_t addr;
        data_word_t wdata;
    } core_req_t;

    // Load channel toward memory, one pulse per block fill
    // The address is always the base of the block
    typedef struct packed {
        logic       req;
        data_word_t addr;
    } load_req_t;

    // Load channel from memory, one valid pulse per returned word
    typedef struct packed {
        logic       valid;
        data_word_t data;
    } load_rsp_t;

    // Store channel toward memory, one pulse per written back word
    typedef struct packed {
        logic       req;
        data_word_t addr;
        data_word_t data;
    } store_req_t;

endpackage : dcache_pkg

`default_nettype wire

// File: rtl/dcache_top.sv
`default_nettype none

module dcache_top
    import dcache_pkg::*;
#(
    // Four words per block
    parameter int OFFSET = 2,
    // Sixteen lines
    parameter int INDEX  = 4
) (
    input  wire logic        clk_i,
    input  wire logic        rst_n_i,

    // Core side
    input  wire logic        req_i,
    input  wire core_req_t   req_data_i,
    output logic             ready_o,
    output data_word_t       rdata_o,
    output logic             valid_o,

    // Memory side
    output load_req_t        load_req_o,
    input  wire load_rsp_t   load_rsp_i,
    output store_req_t       store_req_o,
    input  wire logic        store_done_i
);

    localparam int TAG_W = 30 - INDEX - OFFSET;

    // Controller to array
    data_word_t   arr_addr;
    data_enable_t arr_read;
    data_enable_t arr_write;
    data_word_t   arr_wdata;
    status_t      arr_status;

    // Array to controller
    logic             arr_hit;
    logic             arr_dirty;
    logic [TAG_W-1:0] arr_tag;
    data_word_t       arr_data;

    access_controller #(
        .OFFSET (OFFSET),
        .INDEX  (INDEX)
    ) u_ctrl (
        .clk_i        (clk_i),
        .rst_n_i      (rst_n_i),
        .req_i        (req_i),
        .req_data_i   (req_data_i),
        .ready_o      (ready_o),
        .rdata_o      (rdata_o),
        .valid_o      (valid_o),
        .load_req_o   (load_req_o),
        .load_rsp_i   (load_rsp_i),
        .store_req_o  (store_req_o),
        .store_done_i (store_done_i),
        .arr_hit_i    (arr_hit),
        .arr_dirty_i  (arr_dirty),
        .arr_tag_i    (arr_tag),
        .arr_data_i   (arr_data),
        .arr_addr_o   (arr_addr),
        .arr_read_o   (arr_read),
        .arr_write_o  (arr_write),
        .arr_wdata_o  (arr_wdata),
        .arr_status_o (arr_status)
    );

    cache_array #(
        .OFFSET (OFFSET),
        .INDEX  (INDEX)
    ) u_array (
        .clk_i     (clk_i),
        .rst_n_i   (rst_n_i),
        .addr_i    (arr_addr),
        .read_i    (arr_read),
        .write_i   (arr_write),
        .wdata_i   (arr_wdata),
        .wstatus_i (arr_status),
        .hit_o     (arr_hit),
        .dirty_o   (arr_dirty),
        .tag_o     (arr_tag),
        .rdata_o   (arr_data)
    );

endmodule : dcache_top

`default_nettype wire

// File: run.sh
#!/bin/sh
# Builds the testbench with Verilator and runs it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 -f dcache.f --top-module tb_top -Mdir obj_dir
status=$?
if [ "$status" -ne 0 ]; then
    echo "Verilator build failed with status $status"
    exit 1
fi

output=$(./obj_dir/Vtb_top)
status=$?
printf '%s\n' "$output"
if [ "$status" -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if printf '%s\n' "$output" | grep -qx "RESULT: PASS"; then
    exit 0
fi
exit 1

// File: verif/tb_checker.sv
`default_nettype none

module tb_checker
    import dcache_pkg::*;
#(
    parameter int OFFSET = 2,
    parameter int INDEX  = 4
) (
    input  wire logic       clk_i,
    input  wire logic       rst_n_i,
    input  wire logic       req_i,
    input  wire core_req_t  req_data_i,
    input  wire logic       ready_i,
    input  wire data_word_t rdata_i,
    input  wire logic       valid_i,
    input  wire load_req_t  load_req_i,
    input  wire load_rsp_t  load_rsp_i,
    input  wire store_req_t store_req_i,
    input  wire logic       store_done_i,
    output int              error_count_o,
    output int              check_count_o,
    output int              completed_o,
    output int              hit_count_o,
    output int              writeback_count_o
);

    localparam int LINES     = 2 ** INDEX;
    localparam int WORDS     = 2 ** OFFSET;
    localparam int MEM_WORDS = 4096;

    // Memory as the core sees it, updated when a store completes
    data_word_t ref_mem [MEM_WORDS];

    // Which block each line holds and whether a store reached it since the fill
    data_word_t line_block [LINES];
    logic       line_valid [LINES];
    logic       line_dirty [LINES];

    // Access in flight and what has been seen of it so far
    logic       busy = 1'b0;
    core_req_t  cur;
    logic       cur_hit;
    logic       cur_wb;
    data_word_t victim_base;
    int         accept_cycle;
    int         wb_words;
    int         fill_words;
    logic       load_seen;
    logic       done_seen;

    int cycle      = 0;
    int errors     = 0;
    int checks     = 0;
    int completed  = 0;
    int hits       = 0;
    int writebacks = 0;

    assign error_count_o     = errors;
    assign check_count_o     = checks;
    assign completed_o       = completed;
    assign hit_count_o       = hits;
    assign writeback_count_o = writebacks;

    function automatic int word_index(input data_word_t addr);
        return int'(addr[13:2]);
    endfunction

    function automatic int line_index(input data_word_t addr);
        return int'(addr[2+OFFSET +: INDEX]);
    endfunction

    function automatic data_word_t block_base(input data_word_t addr);
        return addr & ~data_word_t'(WORDS * 4 - 1);
    endfunction

    task automatic compare_value(input string name, input data_word_t got,
                                 input data_word_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("[FAIL] t=%0t %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    task automatic report_problem(input string what);
        errors++;
        $display("ERROR t=%0t %s", $time, what);
    endtask

    initial begin
        for (int i = 0; i < MEM_WORDS; i++) begin
            ref_mem[i] = data_word_t'(i * 4);
        end
    end

    // The model decides hit, clean miss or dirty miss when the request is taken
    task automatic accept_request();
        int line;
        line         = line_index(req_data_i.addr);
        cur          = req_data_i;
        cur_hit      = line_valid[line] && (line_block[line] == block_base(req_data_i.addr));
        cur_wb       = !cur_hit && line_valid[line] && line_dirty[line];
        victim_base  = line_block[line];
        accept_cycle = cycle;
        wb_words     = 0;
        fill_words   = 0;
        load_seen    = 1'b0;
        done_seen    = 1'b0;
        busy         = 1'b1;
        if (cur_hit) begin
            hits++;
        end
        if (cur_wb) begin
            writebacks++;
        end
    endtask

    task automatic complete_access();
        int line;
        int widx;
        line = line_index(cur.addr);
        widx = word_index(cur.addr);
        if (!cur_hit) begin
            if (!load_seen) begin
                report_problem("miss completed without a load request");
            end
            compare_value("fill word count", data_word_t'(fill_words), data_word_t'(WORDS));
        end
        if (cur.write) begin
            ref_mem[widx] = cur.wdata;
        end else begin
            compare_value("rdata_o", rdata_i, ref_mem[widx]);
        end
        // A miss starts the line clean, a store on top of it makes it dirty
        line_dirty[line] = cur.write || (cur_hit && line_dirty[line]);
        line_valid[line] = 1'b1;
        line_block[line] = block_base(cur.addr);
        completed++;
        busy = 1'b0;
    endtask

    task automatic observe_access();
        if (cur_hit && (cycle == accept_cycle + 1) && !valid_i) begin
            report_problem("hit did not complete one cycle after acceptance");
        end
        if (load_req_i.req) begin
            if (cur_hit || load_seen) begin
                report_problem("load request that no miss asked for");
            end
            if (cur_wb && !done_seen) begin
                report_problem("load request before the write-back was done");
            end
            compare_value("load_req_o.addr", load_req_i.addr, block_base(cur.addr));
            load_seen = 1'b1;
        end
        if (load_rsp_i.valid) begin
            fill_words++;
        end
        if (store_req_i.req) begin
            if (!cur_wb) begin
                report_problem("write-back of a block that holds no store");
            end else begin
                // Words leave in ascending order and carry the latest stored values
                compare_value("store_req_o.addr", store_req_i.addr,
                              victim_base + data_word_t'(wb_words * 4));
                compare_value("store_req_o.data", store_req_i.data,
                              ref_mem[word_index(store_req_i.addr)]);
            end
            wb_words++;
        end
        if (store_done_i) begin
            if (!cur_wb || done_seen) begin
                report_problem("store done without a write-back in progress");
            end
            compare_value("write-back word count", data_word_t'(wb_words), data_word_t'(WORDS));
            done_seen = 1'b1;
        end
        if (valid_i) begin
            complete_access();
        end
    endtask

    // Sampled on the falling edge where inputs and outputs are settled
    always @(negedge clk_i) begin
        if (!rst_n_i) begin
            busy = 1'b0;
            for (int i = 0; i < LINES; i++) begin
                line_valid[i] = 1'b0;
                line_dirty[i] = 1'b0;
            end
        end else begin
            cycle++;
            // Ready is high exactly when nothing is in flight
            compare_value("ready_o", data_word_t'(ready_i), data_word_t'(!busy));
            if (!busy && (valid_i || load_req_i.req || store_req_i.req ||
                          load_rsp_i.valid || store_done_i)) begin
                report_problem("DUT activity with no access in flight");
            end
            if (busy) begin
                observe_access();
            end
            if (req_i && ready_i) begin
                accept_request();
            end
        end
    end

endmodule : tb_checker

`default_nettype wire

// File: verif/tb_clock.sv
`default_nettype none

module tb_clock #(
    // Clock period in time units
    parameter int PERIOD       = 20,
    // Number of rising edges with reset held low
    parameter int RESET_CYCLES = 16
) (
    output logic clk_o,
    output logic rst_n_o
);

    initial begin
        clk_o = 1'b0;
        forever begin
            #(PERIOD / 2) clk_o = ~clk_o;
        end
    end

    // Reset is released just after an edge like every other driven input
    initial begin
        rst_n_o = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk_o);
        #2;
        rst_n_o = 1'b1;
    end

endmodule : tb_clock

`default_nettype wire

// File: verif/tb_memory.sv
`default_nettype none

module tb_memory
    import dcache_pkg::*;
#(
    // Words per block as a power of two
    parameter int          OFFSET = 2,
    // Seed for the latency generator
    parameter logic [31:0] SEED   = 32'h1
) (
    input  wire logic       clk_i,
    input  wire load_req_t  load_req_i,
    output load_rsp_t       load_rsp_o,
    input  wire store_req_t store_req_i,
    output logic            store_done_o
);

    localparam int WORDS     = 2 ** OFFSET;
    localparam int MEM_WORDS = 4096;

    data_word_t  mem [MEM_WORDS];
    logic [31:0] rnd_state;
    int          stored_words;

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // Returns a value from 0 up to range minus one
    task automatic draw(input int range, output int value);
        rnd_state = xorshift32(rnd_state);
        value = int'(rnd_state % 32'(range));
    endtask

    // One request gives a whole block in ascending order
    // The first word comes 1 to 6 cycles later and each following word 0 to 2 cycles apart
    task automatic serve_load(input data_word_t base_addr);
        int first;
        int sent;
        int wait_left;
        first = int'(base_addr[13:2]);
        sent  = 0;
        draw(6, wait_left);
        while (sent < WORDS) begin
            @(posedge clk_i);
            #2;
            if (wait_left == 0) begin
                load_rsp_o = '{valid: 1'b1, data: mem[first + sent]};
                sent++;
                draw(3, wait_left);
            end else begin
                load_rsp_o = '0;
                wait_left--;
            end
        end
        @(posedge clk_i);
        #2;
        load_rsp_o = '0;
    endtask

    // Done follows the last word of a write-back after 1 to 4 cycles
    task automatic raise_done();
        int wait_left;
        draw(4, wait_left);
        repeat (wait_left + 1) @(posedge clk_i);
        #2;
        store_done_o = 1'b1;
        @(posedge clk_i);
        #2;
        store_done_o = 1'b0;
    endtask

    initial begin
        // Every word starts out holding its own byte address
        for (int i = 0; i < MEM_WORDS; i++) begin
            mem[i] = data_word_t'(i * 4);
        end
        rnd_state    = SEED;
        stored_words = 0;
        load_rsp_o   = '0;
        store_done_o = 1'b0;
        forever begin
            @(negedge clk_i);
            if (load_req_i.req) begin
                serve_load(load_req_i.addr);
            end else if (store_req_i.req) begin
                mem[int'(store_req_i.addr[13:2])] = store_req_i.data;
                stored_words++;
                if (stored_words == WORDS) begin
                    stored_words = 0;
                    raise_done();
                end
            end
        end
    end

endmodule : tb_memory

`default_nettype wire

// File: verif/tb_top.sv
`default_nettype none

module tb_top
    import dcache_pkg::*;
();

    localparam int          OFFSET       = 2;
    localparam int          INDEX        = 4;
    localparam int          PERIOD       = 20;
    localparam int          NUM_REQ      = 2000;
    localparam int          WINDOW_WORDS = 256;
    localparam int          WORDS        = 2 ** OFFSET;
    localparam logic [31:0] SEED         = 32'h205502db;
    // Worst case of 60 cycles per request plus the reset phase
    localparam int          WATCHDOG     = (NUM_REQ * 60 + 32) * PERIOD;

    logic       clk;
    logic       rst_n;
    logic       req;
    core_req_t  req_data;
    logic       ready;
    data_word_t rdata;
    logic       valid;
    load_req_t  load_req;
    load_rsp_t  load_rsp;
    store_req_t store_req;
    logic       store_done;

    int error_count;
    int check_count;
    int completed;
    int hit_count;
    int writeback_count;
    int issued = 0;

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    tb_clock #(.PERIOD(PERIOD), .RESET_CYCLES(16)) u_clock (.clk_o(clk), .rst_n_o(rst_n));

    dcache_top #(.OFFSET(OFFSET), .INDEX(INDEX)) dut_i (
        .clk_i        (clk),
        .rst_n_i      (rst_n),
        .req_i        (req),
        .req_data_i   (req_data),
        .ready_o      (ready),
        .rdata_o      (rdata),
        .valid_o      (valid),
        .load_req_o   (load_req),
        .load_rsp_i   (load_rsp),
        .store_req_o  (store_req),
        .store_done_i (store_done)
    );

    tb_memory #(.OFFSET(OFFSET), .SEED(SEED ^ 32'h9e3779b9)) u_memory (
        .clk_i        (clk),
        .load_req_i   (load_req),
        .load_rsp_o   (load_rsp),
        .store_req_i  (store_req),
        .store_done_o (store_done)
    );

    tb_checker #(.OFFSET(OFFSET), .INDEX(INDEX)) u_checker (
        .clk_i             (clk),
        .rst_n_i           (rst_n),
        .req_i             (req),
        .req_data_i        (req_data),
        .ready_i           (ready),
        .rdata_i           (rdata),
        .valid_i           (valid),
        .load_req_i        (load_req),
        .load_rsp_i        (load_rsp),
        .store_req_i       (store_req),
        .store_done_i      (store_done),
        .error_count_o     (error_count),
        .check_count_o     (check_count),
        .completed_o       (completed),
        .hit_count_o       (hit_count),
        .writeback_count_o (writeback_count)
    );

    task automatic next_cycle();
        @(posedge clk);
        #2;
    endtask

    // Holds the strobe for one cycle once the controller is idle
    task automatic send_request(input core_req_t r);
        while (!ready) begin
            next_cycle();
        end
        req      = 1'b1;
        req_data = r;
        next_cycle();
        req = 1'b0;
    endtask

    initial begin
        logic [31:0] rnd;
        core_req_t   next_req;
        int          word;
        int          last_word;
        int          gap;
        int          total_errors;
        req       = 1'b0;
        req_data  = '0;
        rnd       = SEED;
        last_word = 0;
        @(posedge rst_n);
        // A few quiet cycles show that nothing happens before the first request
        repeat (3) next_cycle();
        for (int n = 0; n < NUM_REQ; n++) begin
            rnd = xorshift32(rnd);
            if (rnd[1:0] == 2'b00) begin
                // Stay in the block of the previous access so it must hit
                word = (last_word & ~(WORDS - 1)) | (int'(rnd[9:2]) & (WORDS - 1));
            end else begin
                word = int'(rnd[9:2]) % WINDOW_WORDS;
            end
            gap = (rnd[15:14] == 2'b00) ? int'(rnd[17:16]) : 0;
            next_req.write = (rnd[12:10] < 3'd3);
            next_req.addr  = data_word_t'(word * 4);
            rnd = xorshift32(rnd);
            next_req.wdata = rnd;
            send_request(next_req);
            issued++;
            last_word = word;
            repeat (gap) next_cycle();
        end
        while (!ready) begin
            next_cycle();
        end
        repeat (2) next_cycle();

        total_errors = error_count;
        if (completed != issued) begin
            $display("ERROR %0d requests issued but %0d completed", issued, completed);
            total_errors++;
        end
        if (hit_count == 0 || writeback_count == 0) begin
            $display("ERROR stimulus produced no hits or no write-backs");
            total_errors++;
        end
        $display("requests=%0d completed=%0d hits=%0d writebacks=%0d checks=%0d errors=%0d",
                 issued, completed, hit_count, writeback_count, check_count, total_errors);
        if (total_errors == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

    initial begin
        #(WATCHDOG);
        $display("ERROR watchdog expired at %0t after %0d requests", $time, issued);
        $display("RESULT: FAIL");
        $finish;
    end

endmodule : tb_top

`default_nettype wire
